// File: src/corr_cfg_pkg.sv
`default_nettype none

package corr_cfg_pkg;

   // ---------------------------------------------------------------------
   // Array dimensions
   // ---------------------------------------------------------------------
   localparam int N_ANT     = 24;
   localparam int N_LANE    = 12;
   localparam int N_BLOCK   = 2;
   // Small sums so that wrap-around can be reached quickly
   localparam int ACCUM_W   = 10;
   localparam int LANE_W    = 4;
   localparam int ANT_IDX_W = 5;

   // One sample bit from every antenna
   typedef logic [N_ANT-1:0]     ant_vec_t;
   // Time-multiplexed lane within a frame
   typedef logic [LANE_W-1:0]    lane_t;
   // Antenna number used by the pair table
   typedef logic [ANT_IDX_W-1:0] ant_idx_t;
   // Running cosine or sine count
   typedef logic [ACCUM_W-1:0]   sum_t;

   // ---------------------------------------------------------------------
   // Pair table, entry N_LANE*block + lane
   // ---------------------------------------------------------------------
   // Block 0 pairs antenna l with antenna l+12
   // Block 1 pairs antenna l+12 with antenna (l+1) mod 12
   localparam ant_idx_t PAIR_A [N_BLOCK*N_LANE] = '{
      0,  1,  2,  3,  4,  5,  6,  7,  8,  9,  10, 11,
      12, 13, 14, 15, 16, 17, 18, 19, 20, 21, 22, 23
   };

   localparam ant_idx_t PAIR_B [N_BLOCK*N_LANE] = '{
      12, 13, 14, 15, 16, 17, 18, 19, 20, 21, 22, 23,
      1,  2,  3,  4,  5,  6,  7,  8,  9,  10, 11, 0
   };

endpackage

`default_nettype wire

// File: src/corr_bus_pkg.sv
`default_nettype none

package corr_bus_pkg;

   // Word address into the visibility space of all blocks
   localparam int ADDR_W = 6;

   typedef logic [ADDR_W-1:0]                bus_addr_t;
   // One cosine or sine sum per bus word
   typedef logic [corr_cfg_pkg::ACCUM_W-1:0] bus_data_t;

   // Address layout {block, lane[3:0], component}
   localparam int ADR_BLOCK_BIT = 5;
   localparam int ADR_LANE_LSB  = 1;
   // Component 0 is cosine, 1 is sine
   localparam int ADR_COMP_BIT  = 0;

endpackage

`default_nettype wire

// File: src/corr_cos_sin_mac.sv
`timescale 1ns/1ps
`default_nettype none

module corr_cos_sin_mac (
   input  wire                       clk_x,
   input  wire                       rst,
   input  wire                       clr_i,
   input  wire                       en_i,
   input  wire                       a_i,
   input  wire                       br_i,
   input  wire                       bi_i,
   input  wire corr_cfg_pkg::sum_t   dcos_i,
   input  wire corr_cfg_pkg::sum_t   dsin_i,
   output corr_cfg_pkg::sum_t        qcos_o,
   output corr_cfg_pkg::sum_t        qsin_o,
   output logic                      ocos_o,
   output logic                      osin_o
);

   localparam int W = corr_cfg_pkg::ACCUM_W;

   corr_cfg_pkg::sum_t cos_base;
   corr_cfg_pkg::sum_t sin_base;
   logic               cos_hit;
   logic               sin_hit;
   // One extra bit holds the carry out of each sum
   logic [W:0]         cos_nxt;
   logic [W:0]         sin_nxt;

   // One-bit product is a match of signs
   assign cos_hit = ~(a_i ^ br_i);
   assign sin_hit = ~(a_i ^ bi_i);

   // Zero in place of the stored sum restarts the lane
   assign cos_base = clr_i ? '0 : dcos_i;
   assign sin_base = clr_i ? '0 : dsin_i;

   assign cos_nxt = {1'b0, cos_base} + {{W{1'b0}}, cos_hit};
   assign sin_nxt = {1'b0, sin_base} + {{W{1'b0}}, sin_hit};

   // Sums advance only on valid mac cycles
   always_ff @(posedge clk_x) begin
      if (en_i) begin
         qcos_o <= cos_nxt[W-1:0];
         qsin_o <= sin_nxt[W-1:0];
      end
   end

   // Wrap strobes line up with the registered sums
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ocos_o <= 1'b0;
         osin_o <= 1'b0;
      end else if (en_i) begin
         ocos_o <= cos_nxt[W];
         osin_o <= sin_nxt[W];
      end
   end

   // Stored sums may be unknown only while they are being replaced by zero
   a_inputs_known: assert property (@(posedge clk_x) disable iff (rst)
      en_i |-> !$isunknown({clr_i, a_i, br_i, bi_i}) &&
               (clr_i || !$isunknown({dcos_i, dsin_i})));

endmodule

`default_nettype wire

// File: src/corr_lane_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module corr_lane_ctrl (
   input  wire                 clk_x,
   input  wire                 rst,
   input  wire                 en_i,
   input  wire                 sw_i,
   output corr_cfg_pkg::lane_t rd_lane_o,
   output corr_cfg_pkg::lane_t wr_lane_o,
   output logic                wr_en_o,
   output logic                clr_o,
   output logic                bank_o
);

   corr_cfg_pkg::lane_t rd_lane;
   corr_cfg_pkg::lane_t lane_s1;
   corr_cfg_pkg::lane_t lane_s2;
   logic                vld_s1;
   logic                vld_s2;
   logic                pend;
   logic                clr_rd;
   logic                bank_rd;
   logic                bank_s1;
   logic                bank_s2;
   logic                wrap;
   logic                do_sw;

   // Last lane of the frame on an enabled cycle
   assign wrap  = en_i && (rd_lane == corr_cfg_pkg::LANE_W'(corr_cfg_pkg::N_LANE - 1));
   // Switch now, or at the wrap after an earlier request
   assign do_sw = wrap && (sw_i || pend);

   // ---------------------------------------------------------------------
   // Read stage: lane counter, bank and clear state
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         rd_lane <= '0;
         pend    <= 1'b0;
         bank_rd <= 1'b0;
         clr_rd  <= 1'b1;
      end else begin
         if (wrap) rd_lane <= '0;
         else if (en_i) rd_lane <= rd_lane + 1'b1;
         // Request waits for the frame boundary
         if (do_sw) pend <= 1'b0;
         else if (sw_i) pend <= 1'b1;
         if (do_sw) bank_rd <= ~bank_rd;
         // Idle cycles and switches both restart the sums for a frame
         if (!en_i || do_sw) clr_rd <= 1'b1;
         else if (wrap) clr_rd <= 1'b0;
      end
   end

   // ---------------------------------------------------------------------
   // Mac and write stages
   // ---------------------------------------------------------------------
   // Lane, valid and bank move together so late writes keep the old bank
   always_ff @(posedge clk_x) begin
      if (rst) begin
         lane_s1 <= '0;
         lane_s2 <= '0;
         vld_s1  <= 1'b0;
         vld_s2  <= 1'b0;
         clr_o   <= 1'b1;
         bank_s1 <= 1'b0;
         bank_s2 <= 1'b0;
      end else begin
         lane_s1 <= rd_lane;
         lane_s2 <= lane_s1;
         vld_s1  <= en_i;
         vld_s2  <= vld_s1;
         clr_o   <= clr_rd;
         bank_s1 <= bank_rd;
         bank_s2 <= bank_s1;
      end
   end

   assign rd_lane_o = rd_lane;
   assign wr_lane_o = lane_s2;
   assign wr_en_o   = vld_s2;
   assign bank_o    = bank_s2;

   a_lane_range: assert property (@(posedge clk_x) disable iff (rst)
      rd_lane_o < corr_cfg_pkg::LANE_W'(corr_cfg_pkg::N_LANE));

endmodule

`default_nettype wire

// File: src/corr_block.sv
`timescale 1ns/1ps
`default_nettype none

module corr_block #(
   parameter int BLOCK_ID = 0
) (
   input  wire                        clk_x,
   input  wire                        rst,
   input  wire                        en_i,
   input  wire                        sw_i,
   input  wire corr_cfg_pkg::ant_vec_t re_i,
   input  wire corr_cfg_pkg::ant_vec_t im_i,
   input  wire                        stb_i,
   input  wire corr_cfg_pkg::lane_t   lane_adr_i,
   input  wire                        comp_i,
   output logic                       ack_o,
   output corr_bus_pkg::bus_data_t    dat_o,
   output logic                       overflow_cos_o,
   output logic                       overflow_sin_o
);

   // Offset of this block's entries in the pair table
   localparam int PAIR_BASE = BLOCK_ID * corr_cfg_pkg::N_LANE;
   // Two banks of sixteen lane slots, top four never written
   localparam int VIS_DEPTH = 2 << corr_cfg_pkg::LANE_W;

   corr_cfg_pkg::lane_t    rd_lane;
   corr_cfg_pkg::lane_t    wr_lane;
   logic                   wr_en;
   logic                   clr;
   logic                   bank;
   corr_cfg_pkg::ant_idx_t a_idx;
   corr_cfg_pkg::ant_idx_t b_idx;
   logic                   a_r;
   logic                   br_r;
   logic                   bi_r;
   logic                   en_r;
   corr_cfg_pkg::sum_t     dcos_r;
   corr_cfg_pkg::sum_t     dsin_r;
   corr_cfg_pkg::sum_t     qcos;
   corr_cfg_pkg::sum_t     qsin;
   logic                   ocos;
   logic                   osin;
   logic [corr_cfg_pkg::LANE_W:0] rd_vis_adr;

   // Running sums, one per lane
   corr_cfg_pkg::sum_t cos_mem [corr_cfg_pkg::N_LANE];
   corr_cfg_pkg::sum_t sin_mem [corr_cfg_pkg::N_LANE];
   // Visibility buffer addressed by {bank, lane}
   corr_cfg_pkg::sum_t vis_cos [VIS_DEPTH];
   corr_cfg_pkg::sum_t vis_sin [VIS_DEPTH];

   corr_lane_ctrl u_lane_ctrl (
      .clk_x     (clk_x),
      .rst       (rst),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .rd_lane_o (rd_lane),
      .wr_lane_o (wr_lane),
      .wr_en_o   (wr_en),
      .clr_o     (clr),
      .bank_o    (bank)
   );

   // ---------------------------------------------------------------------
   // Read stage: antenna pair and stored sums
   // ---------------------------------------------------------------------
   assign a_idx = corr_cfg_pkg::PAIR_A[PAIR_BASE + int'(rd_lane)];
   assign b_idx = corr_cfg_pkg::PAIR_B[PAIR_BASE + int'(rd_lane)];

   always_ff @(posedge clk_x) begin
      a_r    <= re_i[a_idx];
      br_r   <= re_i[b_idx];
      bi_r   <= im_i[b_idx];
      dcos_r <= cos_mem[rd_lane];
      dsin_r <= sin_mem[rd_lane];
   end

   always_ff @(posedge clk_x) begin
      if (rst) en_r <= 1'b0;
      else en_r <= en_i;
   end

   corr_cos_sin_mac u_mac (
      .clk_x  (clk_x),
      .rst    (rst),
      .clr_i  (clr),
      .en_i   (en_r),
      .a_i    (a_r),
      .br_i   (br_r),
      .bi_i   (bi_r),
      .dcos_i (dcos_r),
      .dsin_i (dsin_r),
      .qcos_o (qcos),
      .qsin_o (qsin),
      .ocos_o (ocos),
      .osin_o (osin)
   );

   // ---------------------------------------------------------------------
   // Write stage: accumulators, visibility buffer and overflow flags
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (wr_en) begin
         cos_mem[wr_lane]         <= qcos;
         sin_mem[wr_lane]         <= qsin;
         vis_cos[{bank, wr_lane}] <= qcos;
         vis_sin[{bank, wr_lane}] <= qsin;
      end
   end

   // Sticky until reset
   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else if (wr_en) begin
         if (ocos) overflow_cos_o <= 1'b1;
         if (osin) overflow_sin_o <= 1'b1;
      end
   end

   // Bus side only sees the bank not being written
   assign rd_vis_adr = {~bank, lane_adr_i};

   // One ack per request, since stb_i is still high in the ack cycle
   always_ff @(posedge clk_x) begin
      if (rst) ack_o <= 1'b0;
      else ack_o <= stb_i && !ack_o;
   end

   always_ff @(posedge clk_x) begin
      if (stb_i) dat_o <= comp_i ? vis_sin[rd_vis_adr] : vis_cos[rd_vis_adr];
   end

endmodule

`default_nettype wire

// File: src/corr_bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

module corr_bus_mux (
   input  wire                           cyc_i,
   input  wire                           stb_i,
   input  wire corr_bus_pkg::bus_addr_t  adr_i,
   output logic [corr_cfg_pkg::N_BLOCK-1:0] blk_stb_o,
   output corr_cfg_pkg::lane_t           lane_adr_o,
   output logic                          comp_o,
   input  wire [corr_cfg_pkg::N_BLOCK-1:0]  blk_ack_i,
   input  wire corr_bus_pkg::bus_data_t  blk_dat_i [corr_cfg_pkg::N_BLOCK],
   output logic                          ack_o,
   output corr_bus_pkg::bus_data_t       dat_o
);

   logic req;
   logic blk_sel;

   // Strobe only counts inside a bus cycle
   assign req     = cyc_i && stb_i;
   assign blk_sel = adr_i[corr_bus_pkg::ADR_BLOCK_BIT];

   assign blk_stb_o[0] = req && !blk_sel;
   assign blk_stb_o[1] = req && blk_sel;

   // Fields shared by both blocks
   assign lane_adr_o = adr_i[corr_bus_pkg::ADR_LANE_LSB +: corr_cfg_pkg::LANE_W];
   assign comp_o     = adr_i[corr_bus_pkg::ADR_COMP_BIT];

   // Return path follows whichever block answers
   assign ack_o = |blk_ack_i;
   assign dat_o = blk_ack_i[1] ? blk_dat_i[1] : blk_dat_i[0];

   // Registered acks in separate blocks never overlap
   always_comb begin
      if (!$isunknown(blk_ack_i)) begin
         a_one_ack: assert ($onehot0(blk_ack_i));
      end
   end

endmodule

`default_nettype wire

// File: src/corr_top.sv
`timescale 1ns/1ps
`default_nettype none

module corr_top (
   input  wire                           clk_x,
   input  wire                           rst,
   input  wire                           en_i,
   input  wire                           sw_i,
   input  wire corr_cfg_pkg::ant_vec_t   re_i,
   input  wire corr_cfg_pkg::ant_vec_t   im_i,
   input  wire                           cyc_i,
   input  wire                           stb_i,
   input  wire                           we_i,
   input  wire corr_bus_pkg::bus_addr_t  adr_i,
   input  wire corr_bus_pkg::bus_data_t  dat_i,
   output logic                          ack_o,
   output corr_bus_pkg::bus_data_t       dat_o,
   output logic [corr_cfg_pkg::N_BLOCK-1:0] overflow_cos_o,
   output logic [corr_cfg_pkg::N_BLOCK-1:0] overflow_sin_o
);

   logic [corr_cfg_pkg::N_BLOCK-1:0] blk_stb;
   logic [corr_cfg_pkg::N_BLOCK-1:0] blk_ack;
   corr_bus_pkg::bus_data_t          blk_dat [corr_cfg_pkg::N_BLOCK];
   corr_cfg_pkg::lane_t              lane_adr;
   logic                             comp;

   // Writes are acked by the blocks but carry no effect

   corr_bus_mux u_bus_mux (
      .cyc_i (cyc_i), .stb_i (stb_i), .adr_i (adr_i),
      .blk_stb_o (blk_stb), .lane_adr_o (lane_adr), .comp_o (comp),
      .blk_ack_i (blk_ack), .blk_dat_i (blk_dat),
      .ack_o (ack_o), .dat_o (dat_o)
   );

   // ---------------------------------------------------------------------
   // Both blocks see the same samples and bus fields
   // ---------------------------------------------------------------------
   corr_block #(.BLOCK_ID(0)) u_block0 (
      .clk_x (clk_x), .rst (rst), .en_i (en_i), .sw_i (sw_i),
      .re_i (re_i), .im_i (im_i),
      .stb_i (blk_stb[0]), .lane_adr_i (lane_adr), .comp_i (comp),
      .ack_o (blk_ack[0]), .dat_o (blk_dat[0]),
      .overflow_cos_o (overflow_cos_o[0]), .overflow_sin_o (overflow_sin_o[0])
   );

   corr_block #(.BLOCK_ID(1)) u_block1 (
      .clk_x (clk_x), .rst (rst), .en_i (en_i), .sw_i (sw_i),
      .re_i (re_i), .im_i (im_i),
      .stb_i (blk_stb[1]), .lane_adr_i (lane_adr), .comp_i (comp),
      .ack_o (blk_ack[1]), .dat_o (blk_dat[1]),
      .overflow_cos_o (overflow_cos_o[1]), .overflow_sin_o (overflow_sin_o[1])
   );

endmodule

`default_nettype wire

// File: tb/corr_tb_vectors.svh
`ifndef CORR_TB_VECTORS_SVH
`define CORR_TB_VECTORS_SVH

// Antenna pattern driven during a phase
typedef enum logic [1:0] {
   SMP_RANDOM,
   SMP_ONES,
   SMP_ALT
} sample_mode_t;

// One phase of the run, always whole frames
typedef struct packed {
   int           frames;
   sample_mode_t mode;
   logic         en;
   logic         sw;      // Pulse sw_i once in the last frame
   logic         check;   // Read back the inactive bank afterwards
   logic [1:0]   ovf_cos; // Expected sticky flags, one bit per block
   logic [1:0]   ovf_sin;
} phase_t;

localparam int N_PHASE = 9;

// Columns: frames, sample mode, en, sw, check, overflow cos, overflow sin
phase_t phase_tab [N_PHASE] = '{
   '{2,    SMP_RANDOM, 1'b0, 1'b0, 1'b0, 2'b00, 2'b00},
   '{5,    SMP_RANDOM, 1'b1, 1'b1, 1'b1, 2'b00, 2'b00},
   '{3,    SMP_RANDOM, 1'b1, 1'b1, 1'b0, 2'b00, 2'b00},
   '{4,    SMP_RANDOM, 1'b1, 1'b1, 1'b1, 2'b00, 2'b00},
   '{3,    SMP_RANDOM, 1'b1, 1'b0, 1'b0, 2'b00, 2'b00},
   '{1,    SMP_RANDOM, 1'b0, 1'b0, 1'b0, 2'b00, 2'b00},
   '{2,    SMP_RANDOM, 1'b1, 1'b1, 1'b1, 2'b00, 2'b00},
   '{3,    SMP_ALT,    1'b1, 1'b1, 1'b1, 2'b00, 2'b00},
   '{1024, SMP_ONES,   1'b1, 1'b1, 1'b1, 2'b11, 2'b11}
};

string phase_name [N_PHASE] = '{
   "idle", "rand_acc", "sw_warm", "sw_clear", "pre_gap",
   "gap", "post_gap", "alt_pattern", "ones_wrap"
};

`endif

// File: tb/corr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module corr_tb;

   // Ack wait per access, and the run budget granted per access
   localparam int ACK_WAIT        = 8;
   localparam int CYCLES_PER_READ = 50;

   logic                             clk_x = 1'b0;
   logic                             rst;
   logic                             en_i;
   logic                             sw_i;
   corr_cfg_pkg::ant_vec_t           re_i;
   corr_cfg_pkg::ant_vec_t           im_i;
   logic                             cyc_i;
   logic                             stb_i;
   logic                             we_i;
   corr_bus_pkg::bus_addr_t          adr_i;
   corr_bus_pkg::bus_data_t          dat_i;
   logic                             ack_o;
   corr_bus_pkg::bus_data_t          dat_o;
   logic [corr_cfg_pkg::N_BLOCK-1:0] overflow_cos_o;
   logic [corr_cfg_pkg::N_BLOCK-1:0] overflow_sin_o;

   `include "corr_tb_vectors.svh"

   // Reference sums per block and lane, visibility copy per bank
   corr_cfg_pkg::sum_t acc_cos [corr_cfg_pkg::N_BLOCK][corr_cfg_pkg::N_LANE];
   corr_cfg_pkg::sum_t acc_sin [corr_cfg_pkg::N_BLOCK][corr_cfg_pkg::N_LANE];
   corr_cfg_pkg::sum_t vis_cos [corr_cfg_pkg::N_BLOCK][2][corr_cfg_pkg::N_LANE];
   corr_cfg_pkg::sum_t vis_sin [corr_cfg_pkg::N_BLOCK][2][corr_cfg_pkg::N_LANE];
   int          m_lane        = 0;
   bit          m_bank        = 1'b0;
   bit          m_clear       = 1'b1;
   bit          m_pend        = 1'b0;
   logic [31:0] rng           = 32'h951d57f5;
   bit          alt_phase     = 1'b0;
   int          err_cnt       = 0;
   int          row_err       = 0;
   int          fail_rows     = 0;
   int          check_cnt     = 0;
   int          cycle_cnt     = 0;
   int          timeout_limit = 0;

   corr_top dut_i (
      .clk_x (clk_x), .rst (rst), .en_i (en_i), .sw_i (sw_i),
      .re_i (re_i), .im_i (im_i),
      .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i), .dat_i (dat_i),
      .ack_o (ack_o), .dat_o (dat_o),
      .overflow_cos_o (overflow_cos_o), .overflow_sin_o (overflow_sin_o)
   );

   always #50 clk_x = ~clk_x;

   // Watchdog on the total cycle budget
   always @(posedge clk_x) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_limit) begin
         $display("Timeout: run did not end within %0d cycles", timeout_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------
   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Frames plus a bus budget for every readback, with slack for reset and gaps
   function automatic int timeout_cycles();
      int n;
      n = 4 + CYCLES_PER_READ + 500;
      for (int i = 0; i < N_PHASE; i++) begin
         n = n + phase_tab[i].frames * corr_cfg_pkg::N_LANE;
         if (phase_tab[i].check)
            n = n + 4 + (2 * corr_cfg_pkg::N_BLOCK * corr_cfg_pkg::N_LANE + 1) * CYCLES_PER_READ;
      end
      return n;
   endfunction

   function automatic corr_bus_pkg::bus_addr_t word_addr(input int blk, input int lane,
                                                         input int comp);
      return corr_bus_pkg::bus_addr_t'((blk << corr_bus_pkg::ADR_BLOCK_BIT) |
                                       (lane << corr_bus_pkg::ADR_LANE_LSB) |
                                       (comp << corr_bus_pkg::ADR_COMP_BIT));
   endfunction

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
      $display("ERR %s %s: expected %0d, actual %0d", name, what, exp, act);
      row_err = row_err + 1;
      err_cnt = err_cnt + 1;
   endtask

   task automatic end_phase(input string name);
      if (row_err == 0) begin
         $display("Phase %s: ok", name);
      end else begin
         $display("Phase %s: %0d errors", name, row_err);
         fail_rows = fail_rows + 1;
      end
      row_err = 0;
   endtask

   // One sample cycle of the reference correlator
   task automatic model_step(input logic en, input logic sw,
                             input corr_cfg_pkg::ant_vec_t re, input corr_cfg_pkg::ant_vec_t im);
      int   idx;
      logic a;
      logic br;
      logic bi;
      if (!en) begin
         m_clear = 1'b1;
      end else begin
         for (int b = 0; b < corr_cfg_pkg::N_BLOCK; b++) begin
            idx = b * corr_cfg_pkg::N_LANE + m_lane;
            a   = re[corr_cfg_pkg::PAIR_A[idx]];
            br  = re[corr_cfg_pkg::PAIR_B[idx]];
            bi  = im[corr_cfg_pkg::PAIR_B[idx]];
            if (m_clear) begin
               acc_cos[b][m_lane] = '0;
               acc_sin[b][m_lane] = '0;
            end
            if (a == br) acc_cos[b][m_lane] = acc_cos[b][m_lane] + corr_cfg_pkg::sum_t'(1);
            if (a == bi) acc_sin[b][m_lane] = acc_sin[b][m_lane] + corr_cfg_pkg::sum_t'(1);
            vis_cos[b][m_bank][m_lane] = acc_cos[b][m_lane];
            vis_sin[b][m_bank][m_lane] = acc_sin[b][m_lane];
         end
         if (sw) m_pend = 1'b1;
         // Frame boundary, switch if requested and restart sums after it
         if (m_lane == corr_cfg_pkg::N_LANE - 1) begin
            m_lane = 0;
            if (m_pend) begin
               m_bank  = ~m_bank;
               m_clear = 1'b1;
               m_pend  = 1'b0;
            end else begin
               m_clear = 1'b0;
            end
         end else begin
            m_lane = m_lane + 1;
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      en_i = 1'b0;
      sw_i = 1'b0;
      repeat (n) begin
         model_step(1'b0, 1'b0, re_i, im_i);
         @(posedge clk_x);
         #1;
      end
   endtask

   // Single bus access, request held until ack
   task automatic bus_access(input logic we, input corr_bus_pkg::bus_addr_t adr,
                             input corr_bus_pkg::bus_data_t wdat, input string name,
                             output corr_bus_pkg::bus_data_t rdat, output logic ok);
      int lat;
      lat   = 0;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdat;
      do begin
         @(posedge clk_x);
         #1;
         lat = lat + 1;
      end while (ack_o !== 1'b1 && lat < ACK_WAIT);
      ok    = (ack_o === 1'b1);
      rdat  = dat_o;
      // Request stays up through the ack cycle and drops after its edge
      @(posedge clk_x);
      #1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      if (!ok) begin
         $display("Phase %s: bus timeout, no ack for address 0x%h", name, adr);
         row_err = row_err + 1;
         err_cnt = err_cnt + 1;
      end else begin
         check_cnt = check_cnt + 2;
         if (lat != 1) report_mismatch(name, "ack latency", 32'd1, 32'(lat));
         // Held request must not earn a second ack
         if (ack_o !== 1'b0) report_mismatch(name, "second ack_o", 32'd0, 32'(ack_o));
      end
   endtask

   // ---------------------------------------------------------------------
   // Phase stimulus and readback
   // ---------------------------------------------------------------------
   task automatic run_frames(input int row);
      phase_t                 ph;
      logic                   sw;
      int                     pulse_lane;
      corr_cfg_pkg::ant_vec_t re;
      corr_cfg_pkg::ant_vec_t im;
      ph = phase_tab[row];
      // Pulse position moves with the row, one row lands on the wrap cycle
      pulse_lane = (row * 5) % corr_cfg_pkg::N_LANE;
      for (int f = 0; f < ph.frames; f++) begin
         for (int l = 0; l < corr_cfg_pkg::N_LANE; l++) begin
            case (ph.mode)
               SMP_RANDOM: begin
                  rng = next_random(rng);
                  re  = rng[corr_cfg_pkg::N_ANT-1:0];
                  rng = next_random(rng);
                  im  = rng[corr_cfg_pkg::N_ANT-1:0];
               end
               SMP_ONES: begin
                  re = '1;
                  im = '1;
               end
               default: begin
                  alt_phase = ~alt_phase;
                  re = alt_phase ? {(corr_cfg_pkg::N_ANT/2){2'b10}}
                                 : {(corr_cfg_pkg::N_ANT/2){2'b01}};
                  im = ~re;
               end
            endcase
            sw   = ph.en && ph.sw && (f == ph.frames - 1) && (l == pulse_lane);
            en_i = ph.en;
            sw_i = sw;
            re_i = re;
            im_i = im;
            model_step(ph.en, sw, re, im);
            @(posedge clk_x);
            #1;
         end
      end
      sw_i = 1'b0;
   endtask

   task automatic read_back(input string name);
      corr_bus_pkg::bus_data_t exp;
      corr_bus_pkg::bus_data_t rdat;
      logic                    ok;
      bit                      rd_bank;
      // Last writes of the old frame drain into the inactive bank
      idle_cycles(4);
      rd_bank = ~m_bank;
      // Complement written to one word, which must read back unchanged
      bus_access(1'b1, word_addr(1, 2, 1), ~vis_sin[1][rd_bank][2], name, rdat, ok);
      for (int blk = 0; blk < corr_cfg_pkg::N_BLOCK; blk++) begin
         for (int lane = 0; lane < corr_cfg_pkg::N_LANE; lane++) begin
            for (int comp = 0; comp < 2; comp++) begin
               exp = (comp == 1) ? vis_sin[blk][rd_bank][lane] : vis_cos[blk][rd_bank][lane];
               bus_access(1'b0, word_addr(blk, lane, comp), '0, name, rdat, ok);
               if (ok) begin
                  check_cnt = check_cnt + 1;
                  if (rdat !== exp)
                     report_mismatch(name, $sformatf("blk %0d lane %0d comp %0d",
                                     blk, lane, comp), 32'(exp), 32'(rdat));
               end
            end
         end
      end
   endtask

   initial begin
      phase_t                  ph;
      corr_bus_pkg::bus_data_t rdat;
      logic                    ok;
      rst   = 1'b1;
      en_i  = 1'b0;
      sw_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      dat_i = '0;
      timeout_limit = timeout_cycles();
      repeat (4) @(posedge clk_x);
      #1;
      rst = 1'b0;

      // Quiet bus and clear flags out of reset
      check_cnt = check_cnt + 3;
      if (ack_o !== 1'b0) report_mismatch("reset", "ack_o", 32'd0, 32'(ack_o));
      if (overflow_cos_o !== '0)
         report_mismatch("reset", "overflow_cos_o", 32'd0, 32'(overflow_cos_o));
      if (overflow_sin_o !== '0)
         report_mismatch("reset", "overflow_sin_o", 32'd0, 32'(overflow_sin_o));
      // Bank holds no sums yet, handshake only
      bus_access(1'b0, word_addr(0, 0, 0), '0, "reset", rdat, ok);
      end_phase("reset");

      for (int i = 0; i < N_PHASE; i++) begin
         ph = phase_tab[i];
         run_frames(i);
         if (ph.check) read_back(phase_name[i]);
         check_cnt = check_cnt + 2;
         if (overflow_cos_o !== ph.ovf_cos)
            report_mismatch(phase_name[i], "overflow_cos_o", 32'(ph.ovf_cos),
                            32'(overflow_cos_o));
         if (overflow_sin_o !== ph.ovf_sin)
            report_mismatch(phase_name[i], "overflow_sin_o", 32'(ph.ovf_sin),
                            32'(overflow_sin_o));
         end_phase(phase_name[i]);
      end

      $display("Done: %0d phases, %0d failed, %0d checks, %0d errors",
               N_PHASE + 1, fail_rows, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+tb
src/corr_cfg_pkg.sv
src/corr_bus_pkg.sv
src/corr_cos_sin_mac.sv
src/corr_lane_ctrl.sv
src/corr_block.sv
src/corr_bus_mux.sv
src/corr_top.sv
tb/corr_tb.sv

// File: Makefile
# Verilator build and run of the correlator testbench

VERILATOR ?= verilator
TOP       ?= corr_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard src/*.sv tb/*.sv tb/*.svh)
PASS_MSG := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) VFLAGS='$(VFLAGS)'"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
